/* build.f */
rtl/uart_pkg.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_rx_status.sv
rtl/uart_top.sv
test/tb_clk_gen.sv
test/tb_uart.sv

/* rtl/uart_pkg.sv */
// shared types, register map and state encodings for the APB UART; import into each module
package uart_pkg;

  localparam int BYTE_W = 8;
  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 32;

  typedef logic [BYTE_W-1:0]     byte_t;
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_word_t;

  // register map, one word each
  localparam apb_addr_t ADDR_DATA   = 4'h0;
  localparam apb_addr_t ADDR_STATUS = 4'h4;
  localparam apb_addr_t ADDR_CTRL   = 4'h8;

  // bit positions in STATUS
  localparam int ST_RX_VALID = 0;
  localparam int ST_TX_BUSY  = 1;
  localparam int ST_OVERRUN  = 2;
  localparam int ST_BREAK    = 3;
  localparam int ST_FRAMING  = 4;

  // one received character, valid is a single-cycle pulse
  typedef struct packed {
    byte_t data;
    logic  stop_ok;
    logic  valid;
  } rx_frame_t;

  typedef struct packed {
    logic rx_valid;
    logic overrun;
    logic brk;
    logic framing;
  } uart_status_t;

  // all single-cycle pulses from the register block
  typedef struct packed {
    logic rd_data;
    logic clr_overrun;
    logic clr_break;
    logic clr_framing;
  } flag_clear_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

/* rtl/uart_regs.sv */
// APB register block of the UART: decodes accesses, starts transmits and issues flag clears
`timescale 1ns/1ps

module uart_regs
  import uart_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  apb_addr_t    paddr,
  input  apb_word_t    pwdata,
  output apb_word_t    prdata,
  output logic         pready,
  output logic         pslverr,
  output logic         tx_start,
  output byte_t        tx_byte,
  input  logic         tx_busy,
  input  byte_t        rx_byte,
  input  uart_status_t status,
  output flag_clear_t  clear,
  output logic         loopback
);

  logic      access;
  logic      wr_en;
  logic      rd_en;
  logic      sel_data;
  logic      sel_status;
  logic      sel_ctrl;
  logic      mapped;
  apb_word_t status_word;

  // zero wait states, every access phase completes
  assign pready = 1'b1;

  assign access = psel & penable;
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;

  assign sel_data   = (paddr == ADDR_DATA);
  assign sel_status = (paddr == ADDR_STATUS);
  assign sel_ctrl   = (paddr == ADDR_CTRL);
  assign mapped     = sel_data | sel_status | sel_ctrl;

  // a byte written while the shifter is busy is dropped
  assign pslverr = access & (~mapped | (pwrite & sel_data & tx_busy));

  assign tx_start = wr_en & sel_data & ~tx_busy;
  assign tx_byte  = pwdata[BYTE_W-1:0];

  // pulses land in the status block on the closing edge of the access
  assign clear.rd_data     = rd_en & sel_data;
  assign clear.clr_overrun = wr_en & sel_status & pwdata[ST_OVERRUN];
  assign clear.clr_break   = wr_en & sel_status & pwdata[ST_BREAK];
  assign clear.clr_framing = wr_en & sel_status & pwdata[ST_FRAMING];

  always_comb begin
    status_word              = '0;
    status_word[ST_RX_VALID] = status.rx_valid;
    status_word[ST_TX_BUSY]  = tx_busy;
    status_word[ST_OVERRUN]  = status.overrun;
    status_word[ST_BREAK]    = status.brk;
    status_word[ST_FRAMING]  = status.framing;
  end

  // read mux, quiet outside a read access
  always_comb begin
    prdata = '0;
    if (rd_en) begin
      if (sel_data) begin
        prdata = apb_word_t'(rx_byte);
      end else if (sel_status) begin
        prdata = status_word;
      end else if (sel_ctrl) begin
        prdata = apb_word_t'(loopback);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loopback <= 1'b0;
    end else if (wr_en && sel_ctrl) begin
      loopback <= pwdata[0];
    end
  end

  // an access phase is always preceded by its setup phase
  a_apb_setup_first: assert property (
    @(posedge clk) disable iff (!rst_n)
    (psel && penable) |-> $past(psel && !penable)
  ) else $error("apb access phase without setup phase");

endmodule

/* rtl/uart_rx.sv */
// UART receiver: synchronizes the line, finds the start bit and samples each bit at mid-bit
`timescale 1ns/1ps

module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rx_serial,
  output rx_frame_t frame
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam int HALF = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;
  localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] MID_LAST = CW'(HALF - 1);

  rx_state_e     state;
  logic [1:0]    sync_q;
  logic          rx_s;
  logic          rx_d;
  logic          fall;
  logic [CW-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  logic          bit_end;
  byte_t         shift;
  logic          stop_q;
  logic          valid_q;

  // two-flop synchronizer, idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b11;
      rx_d   <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], rx_serial};
      rx_d   <= rx_s;
    end
  end

  assign rx_s    = sync_q[1];
  assign fall    = rx_d & ~rx_s;
  assign bit_end = (clk_cnt == BIT_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // recheck at mid start bit, a short glitch falls back to idle
          if (clk_cnt == MID_LAST) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          // frame reported right after the stop sample
          if (bit_end) begin
            valid_q <= 1'b1;
            state   <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) begin
      shift <= {rx_s, shift[BYTE_W-1:1]};
    end
    if (state == RX_STOP && bit_end) begin
      stop_q <= rx_s;
    end
  end

  assign frame.data    = shift;
  assign frame.stop_ok = stop_q;
  assign frame.valid   = valid_q;

endmodule

/* rtl/uart_rx_status.sv */
// receive holding register with sticky rx_valid, overrun, break and framing flags
`timescale 1ns/1ps

module uart_rx_status
  import uart_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  rx_frame_t    frame,
  input  flag_clear_t  clear,
  output byte_t        rx_byte,
  output uart_status_t status
);

  logic is_break;
  logic is_framing;

  assign is_break   = frame.valid & ~frame.stop_ok & (frame.data == '0);
  assign is_framing = frame.valid & ~frame.stop_ok & (frame.data != '0);

  // a newer frame simply overwrites the old byte
  always_ff @(posedge clk) begin
    if (frame.valid) begin
      rx_byte <= frame.data;
    end
  end

  // set beats clear when both arrive in one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status <= '0;
    end else begin
      if (frame.valid) begin
        status.rx_valid <= 1'b1;
      end else if (clear.rd_data) begin
        status.rx_valid <= 1'b0;
      end

      if (frame.valid && status.rx_valid) begin
        status.overrun <= 1'b1;
      end else if (clear.clr_overrun) begin
        status.overrun <= 1'b0;
      end

      if (is_break) begin
        status.brk <= 1'b1;
      end else if (clear.clr_break) begin
        status.brk <= 1'b0;
      end

      if (is_framing) begin
        status.framing <= 1'b1;
      end else if (clear.clr_framing) begin
        status.framing <= 1'b0;
      end
    end
  end

  a_break_xor_framing: assert property (
    @(posedge clk) disable iff (!rst_n)
    !($rose(status.brk) && $rose(status.framing))
  ) else $error("break and framing set by the same frame");

endmodule

/* rtl/uart_top.sv */
// APB UART top level: wires the register block, transmitter, receiver and status keeper
`timescale 1ns/1ps

module uart_top
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_word_t pwdata,
  output apb_word_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      rx_pin,
  output logic      tx_pin
);

  logic         tx_start;
  byte_t        tx_byte;
  logic         tx_busy;
  logic         tx_line;
  logic         rx_serial;
  logic         loopback;
  rx_frame_t    frame;
  byte_t        rx_byte;
  uart_status_t status;
  flag_clear_t  clear;

  // internal loopback feeds the receiver from the transmitter
  assign rx_serial = loopback ? tx_line : rx_pin;
  assign tx_pin    = tx_line;

  uart_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_byte  (rx_byte),
    .status   (status),
    .clear    (clear),
    .loopback (loopback)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_line  (tx_line),
    .tx_busy  (tx_busy)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_serial (rx_serial),
    .frame     (frame)
  );

  uart_rx_status u_rx_status (
    .clk     (clk),
    .rst_n   (rst_n),
    .frame   (frame),
    .clear   (clear),
    .rx_byte (rx_byte),
    .status  (status)
  );

endmodule

/* rtl/uart_tx.sv */
// UART transmitter: serializes one byte as start, 8 data bits LSB first, stop
`timescale 1ns/1ps

module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  tx_line,
  output logic  tx_busy
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

  tx_state_e     state;
  logic [CW-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  byte_t         shift;
  logic          bit_end;

  assign bit_end = (clk_cnt == BIT_LAST);
  assign tx_busy = (state != TX_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx_line <= 1'b1;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          clk_cnt <= '0;
          if (tx_start) begin
            state   <= TX_START;
            tx_line <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_idx <= '0;
            tx_line <= shift[0];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state   <= TX_STOP;
              tx_line <= 1'b1;
            end else begin
              tx_line <= shift[1];
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // data shifter
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && tx_start) begin
      shift <= tx_byte;
    end else if (state == TX_DATA && bit_end) begin
      shift <= {1'b0, shift[BYTE_W-1:1]};
    end
  end

  a_no_start_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  ) else $error("tx_start while transmitter busy");

endmodule

/* test/tb_clk_gen.sv */
// testbench clock and active-low reset source, instanced once by the testbench top
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* test/tb_uart.sv */
// simulation top that drives the APB UART over APB and its serial pin and checks it with assertions
`timescale 1ns/1ps

module tb_uart
  import uart_pkg::*;
();

  localparam int CLKS_PER_BIT = 4;
  localparam int CLK_PERIOD   = 20;
  localparam int NUM_FRAMES   = 13;
  localparam int MAX_POLLS    = 40;
  localparam int TIMEOUT_NS   = (NUM_FRAMES + 4) * 12 * CLKS_PER_BIT * CLK_PERIOD
                                + 400 * CLK_PERIOD;

  logic      clk;
  logic      rst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_word_t pwdata;
  apb_word_t prdata;
  logic      pready;
  logic      pslverr;
  logic      rx_pin;
  logic      tx_pin;
  apb_word_t cap_rdata;
  logic      cap_err;
  integer    seed;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rx_pin  (rx_pin),
    .tx_pin  (tx_pin)
  );

  // response of the access phase taken on its closing edge
  always @(posedge clk) begin
    if (psel && penable) begin
      cap_rdata <= prdata;
      cap_err   <= pslverr;
    end
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
  endtask

  task automatic expect_word(input apb_word_t got, input apb_word_t exp, input string what);
    assert (got === exp)
      else report_mismatch($sformatf("%s: got 0x%0h, expected 0x%0h", what, got, exp));
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_word_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    err     = cap_err;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_word_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    data    = cap_rdata;
    err     = cap_err;
  endtask

  task automatic write_expect(input apb_addr_t addr, input apb_word_t data,
                              input logic exp_err, input string what);
    logic err;
    apb_write(addr, data, err);
    expect_word(apb_word_t'(err), apb_word_t'(exp_err), {what, " pslverr"});
  endtask

  task automatic read_expect(input apb_addr_t addr, input apb_word_t exp, input string what);
    apb_word_t data;
    logic      err;
    apb_read(addr, data, err);
    expect_word(apb_word_t'(err), '0, {what, " pslverr"});
    expect_word(data, exp, what);
  endtask

  // poll STATUS until one flag reaches the wanted level
  task automatic wait_status(input int bit_pos, input logic level, input string what);
    apb_word_t data;
    logic      err;
    logic      done;
    int        polls;
    done  = 1'b0;
    polls = 0;
    while (!done && polls < MAX_POLLS) begin
      apb_read(ADDR_STATUS, data, err);
      done = (data[bit_pos] === level);
      polls++;
    end
    if (!done) begin
      stop_with_failure($sformatf("no %s after %0d STATUS reads", what, MAX_POLLS));
    end
  endtask

  task automatic send_serial(input byte_t data, input logic stop_bit);
    int i;
    @(negedge clk);
    rx_pin = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge clk);
    for (i = 0; i < BYTE_W; i++) begin
      rx_pin = data[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    rx_pin = stop_bit;
    repeat (CLKS_PER_BIT) @(negedge clk);
    // line back high for one idle bit
    rx_pin = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  // entered half a cycle into the start bit and samples near each bit middle
  task automatic sample_tx_frame(input byte_t data);
    int i;
    @(negedge clk);
    expect_word(tx_pin, 0, "tx start bit");
    for (i = 0; i < BYTE_W; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      expect_word(tx_pin, data[i], $sformatf("tx data bit %0d", i));
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    expect_word(tx_pin, 1, "tx stop bit");
  endtask

  task automatic reset_defaults();
    apb_word_t data;
    logic      err;
    expect_word(tx_pin, 1, "tx_pin after reset");
    read_expect(ADDR_STATUS, '0, "STATUS after reset");
    read_expect(ADDR_CTRL, '0, "CTRL after reset");
    apb_read(4'hC, data, err);
    expect_word(err, 1, "pslverr on unmapped read");
  endtask

  task automatic loopback_bytes();
    byte_t tx_b;
    int    i;
    write_expect(ADDR_CTRL, 32'h1, 1'b0, "CTRL loopback on");
    read_expect(ADDR_CTRL, 32'h1, "CTRL readback");
    for (i = 0; i < 8; i++) begin
      tx_b = byte_t'($random(seed));
      wait_status(ST_TX_BUSY, 1'b0, "tx_busy low");
      write_expect(ADDR_DATA, apb_word_t'(tx_b), 1'b0, "DATA write");
      wait_status(ST_RX_VALID, 1'b1, "rx_valid");
      read_expect(ADDR_DATA, apb_word_t'(tx_b), "loopback byte");
      read_expect(ADDR_STATUS, '0, "STATUS after DATA read");
    end
  endtask

  task automatic tx_frame_and_reject();
    byte_t tx_b;
    write_expect(ADDR_CTRL, '0, 1'b0, "CTRL loopback off");
    wait_status(ST_TX_BUSY, 1'b0, "tx_busy low");
    tx_b = byte_t'($random(seed));
    write_expect(ADDR_DATA, apb_word_t'(tx_b), 1'b0, "DATA write");
    fork
      sample_tx_frame(tx_b);
      begin
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        write_expect(ADDR_DATA, apb_word_t'(~tx_b), 1'b1, "DATA write while busy");
      end
    join
    wait_status(ST_TX_BUSY, 1'b0, "tx_busy low after frame");
    read_expect(ADDR_STATUS, '0, "STATUS after transmit");
  endtask

  task automatic overrun_flag();
    byte_t first_b;
    byte_t second_b;
    first_b  = byte_t'($random(seed));
    second_b = byte_t'($random(seed));
    // the second byte must differ to show it replaced the first
    if (second_b == first_b) begin
      second_b = ~first_b;
    end
    send_serial(first_b, 1'b1);
    send_serial(second_b, 1'b1);
    wait_status(ST_OVERRUN, 1'b1, "overrun");
    read_expect(ADDR_STATUS, (1 << ST_RX_VALID) | (1 << ST_OVERRUN), "STATUS after two frames");
    read_expect(ADDR_DATA, apb_word_t'(second_b), "DATA after overrun");
    read_expect(ADDR_STATUS, 1 << ST_OVERRUN, "STATUS after DATA read");
    write_expect(ADDR_STATUS, 1 << ST_OVERRUN, 1'b0, "overrun clear");
    read_expect(ADDR_STATUS, '0, "STATUS after overrun clear");
  endtask

  task automatic break_and_framing();
    byte_t frame_b;
    frame_b = byte_t'($random(seed));
    if (frame_b == '0) begin
      frame_b = 8'h5a;
    end
    send_serial(8'h00, 1'b0);
    wait_status(ST_RX_VALID, 1'b1, "rx_valid after break");
    read_expect(ADDR_STATUS, (1 << ST_RX_VALID) | (1 << ST_BREAK), "STATUS after break");
    read_expect(ADDR_DATA, '0, "DATA after break");
    // no stray frame once the line is high again
    read_expect(ADDR_STATUS, 1 << ST_BREAK, "STATUS with line idle");
    send_serial(frame_b, 1'b0);
    wait_status(ST_RX_VALID, 1'b1, "rx_valid after framing error");
    read_expect(ADDR_STATUS, (1 << ST_RX_VALID) | (1 << ST_BREAK) | (1 << ST_FRAMING),
                "STATUS after framing error");
    read_expect(ADDR_DATA, apb_word_t'(frame_b), "DATA after framing error");
    write_expect(ADDR_STATUS, 1 << ST_BREAK, 1'b0, "break clear");
    read_expect(ADDR_STATUS, 1 << ST_FRAMING, "STATUS after break clear");
    write_expect(ADDR_STATUS, 1 << ST_FRAMING, 1'b0, "framing clear");
    read_expect(ADDR_STATUS, '0, "STATUS after framing clear");
  endtask

  // accepted DATA write starts the frame one cycle later
  a_tx_start_next: assert property (
    @(posedge clk) disable iff (!rst_n)
    (psel && penable && pwrite && paddr == ADDR_DATA && !pslverr) |=> !tx_pin
  ) else report_mismatch("tx_pin not low the cycle after an accepted DATA write");

  a_pready_high: assert property (
    @(posedge clk) disable iff (!rst_n) pready
  ) else report_mismatch("pready low");

  a_err_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) pslverr |-> (psel && penable)
  ) else report_mismatch("pslverr outside an access phase");

  initial begin
    seed    = 24;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rx_pin  = 1'b1;
    wait (rst_n === 1'b1);
    reset_defaults();
    loopback_bytes();
    tx_frame_and_reject();
    overrun_flag();
    break_and_framing();
    repeat (4) @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    stop_with_failure($sformatf("simulation timed out after %0d ns", TIMEOUT_NS));
  end

endmodule
